//--- bench/plus_video_stimulus.txt
# W addr data | R addr expected_byte | E section_name (all numbers hex)
# P plus hblank vblank r g b sprite_active sprite_index expected_r expected_g expected_b
P 0 0 0 3 2 1 0 0 3 2 1
P 0 1 1 1 2 3 1 5 1 2 3
W 0082 05
R 0082 00
E passthrough
P 1 0 0 1 1 1 0 0 1 1 1
W 0090 01
W 7F63 2D
W 7F6A FC
W 0082 A7
R 0090 01
R 7F63 2D
R 7F6A 3C
R 0082 A7
R 0041 00
E registers
P 1 0 0 1 0 2 1 3 2 3 1
P 1 0 0 0 1 0 1 A 3 3 0
P 1 1 0 3 3 3 1 3 0 0 0
P 1 0 1 3 3 3 0 0 0 0 0
E sprite_blank
W 0082 04
P 1 0 0 3 2 1 0 0 3 2 1
P 1 1 0 0 0 0 0 0 0 0 0
P 1 0 0 3 2 1 0 0 1 1 0
P 1 1 0 0 0 0 0 0 0 0 0
P 1 0 0 2 3 3 0 0 2 3 3
W 0082 05
P 1 0 0 3 3 2 0 0 1 1 1
P 1 0 0 0 0 0 1 3 2 3 1
W 0090 00
P 1 0 0 3 3 2 0 0 3 3 2
E scanline_shadow
W 0090 01
W 0082 01
P 1 0 0 3 0 0 0 0 0 0 0
P 1 0 0 0 3 0 0 0 0 3 0
P 1 0 0 0 0 3 0 0 0 3 0
P 1 0 0 1 2 3 0 0 1 2 3
P 1 0 0 2 2 2 1 A 3 3 0
P 1 0 0 2 1 0 0 0 2 1 0
E double_width

//--- filelist.f
source/video_pixel_pkg.sv
source/video_reg_pkg.sv
source/video_regs.sv
source/raster_counter.sv
source/pixel_pipeline.sv
source/plus_video.sv
bench/plus_video_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = plus_video_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^STATUS: PASS$$' $(LOG)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/plus_video_tb.sv
`timescale 1ns/1ps

module plus_video_tb;

    localparam int    CLK_PERIOD = 40;
    localparam int    READ_WAIT  = 4;
    localparam string STIM_FILE  = "bench/plus_video_stimulus.txt";

    localparam video_pixel_pkg::rgb_t IDLE_EXP = video_pixel_pkg::BLACK;

    logic                                clk_sys;
    logic                                reset;
    logic                                plus_mode;
    video_reg_pkg::cpu_bus_t             cpu;
    video_pixel_pkg::pixel_in_t          pix;
    logic [video_reg_pkg::DATA_W-1:0]    rdata;
    logic                                rdata_valid;
    video_pixel_pkg::rgb_t               rgb_out;

    // Expected output of one cycle, compared two edges later
    video_pixel_pkg::rgb_t exp_q[$];
    video_pixel_pkg::rgb_t due;
    int   total_checks;
    int   total_errors;
    int   sect_checks;
    int   sect_errors;
    int   line_count;
    logic lines_known;

    plus_video DUT (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .plus_mode   (plus_mode),
        .cpu         (cpu),
        .pix         (pix),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rgb_out     (rgb_out)
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    ////////////////////////////////////////////////////////////
    // Compare and report
    ////////////////////////////////////////////////////////////

    task automatic check_rgb(input string name, input video_pixel_pkg::rgb_t expected,
                             input video_pixel_pkg::rgb_t actual);
        sect_checks++;
        total_checks++;
        if (actual !== expected) begin
            sect_errors++;
            total_errors++;
            $display("ERR time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name,
                              input logic [video_reg_pkg::DATA_W-1:0] expected,
                              input logic [video_reg_pkg::DATA_W-1:0] actual);
        sect_checks++;
        total_checks++;
        if (actual !== expected) begin
            sect_errors++;
            total_errors++;
            $display("ERR time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        sect_checks++;
        total_checks++;
        if (actual !== expected) begin
            sect_errors++;
            total_errors++;
            $display("ERR time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        sect_errors++;
        total_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Output checker, sampled well after the edge
    always @(posedge clk_sys) begin
        #1;
        if (exp_q.size() == 2) begin
            due = exp_q.pop_front();
            check_rgb("rgb_out", due, rgb_out);
        end
    end

    ////////////////////////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////////////////////////

    // Queue this cycle's expectation, move to the next drive point
    task automatic next_cycle(input video_pixel_pkg::rgb_t e);
        exp_q.push_back(e);
        @(posedge clk_sys);
        #2;
    endtask

    // Fully blanked pixel between bus accesses
    task automatic drive_idle();
        pix        = '0;
        pix.hblank = 1'b1;
        pix.vblank = 1'b1;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        drive_idle();
        cpu.addr  = addr;
        cpu.wdata = data;
        cpu.wr    = 1'b1;
        next_cycle(IDLE_EXP);
        cpu.wr = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, input logic [7:0] expected);
        int waited;
        drive_idle();
        cpu.addr = addr;
        cpu.rd   = 1'b1;
        next_cycle(IDLE_EXP);
        cpu.rd = 1'b0;
        waited = 0;
        while (!rdata_valid && waited < READ_WAIT) begin
            next_cycle(IDLE_EXP);
            waited++;
        end
        if (rdata_valid) begin
            if (waited != 0) begin
                report_failure($sformatf("read of address %h took %0d cycles instead of one",
                                         addr, waited + 1));
            end
            check_byte("rdata", expected, rdata);
            // Valid is a one-cycle pulse
            next_cycle(IDLE_EXP);
            check_flag("rdata_valid", 1'b0, rdata_valid);
        end else begin
            report_failure($sformatf("read of address %h never raised rdata_valid", addr));
        end
    endtask

    // Two idle cycles flush the pixels still in flight
    task automatic end_section(input string name);
        drive_idle();
        next_cycle(IDLE_EXP);
        next_cycle(IDLE_EXP);
        $display("section %s done: %0d checks, %0d errors", name, sect_checks, sect_errors);
        sect_checks = 0;
        sect_errors = 0;
    endtask

    task automatic run_stimulus(input int fd);
        string      tok;
        string      rest;
        int         code;
        logic [15:0] f_addr;
        logic [7:0] f_data;
        logic       f_plus;
        logic       f_hb;
        logic       f_vb;
        logic       f_sa;
        logic [1:0] f_r;
        logic [1:0] f_g;
        logic [1:0] f_b;
        logic [1:0] e_r;
        logic [1:0] e_g;
        logic [1:0] e_b;
        logic [3:0] f_si;
        video_pixel_pkg::rgb_t e;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "W") begin
                code = $fscanf(fd, "%h %h", f_addr, f_data);
                if (code != 2) begin
                    report_failure("write line in the stimulus file is missing fields");
                end
                write_reg(f_addr, f_data);
            end else if (tok == "R") begin
                code = $fscanf(fd, "%h %h", f_addr, f_data);
                if (code != 2) begin
                    report_failure("read line in the stimulus file is missing fields");
                end
                read_reg(f_addr, f_data);
            end else if (tok == "P") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_plus, f_hb, f_vb,
                               f_r, f_g, f_b, f_sa, f_si, e_r, e_g, e_b);
                if (code != 11) begin
                    report_failure("pixel line in the stimulus file is missing fields");
                end
                plus_mode         = f_plus;
                pix.hblank        = f_hb;
                pix.vblank        = f_vb;
                pix.colour.r      = f_r;
                pix.colour.g      = f_g;
                pix.colour.b      = f_b;
                pix.sprite_active = f_sa;
                pix.sprite_index  = f_si;
                e.r = e_r;
                e.g = e_g;
                e.b = e_b;
                next_cycle(e);
            end else if (tok == "E") begin
                code = $fscanf(fd, "%s", rest);
                if (code != 1) begin
                    report_failure("section end in the stimulus file has no name");
                end
                end_section(rest);
            end else begin
                report_failure($sformatf("unknown stimulus line kind %s", tok));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        string text;
        clk_sys      = 1'b0;
        reset        = 1'b1;
        plus_mode    = 1'b0;
        cpu          = '0;
        pix          = '0;
        total_checks = 0;
        total_errors = 0;
        sect_checks  = 0;
        sect_errors  = 0;
        line_count   = 0;
        lines_known  = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
        end
        lines_known = 1'b1;
        repeat (8) @(posedge clk_sys);
        #2;
        // Outputs idle while in reset
        check_rgb("rgb_out", video_pixel_pkg::BLACK, rgb_out);
        check_flag("rdata_valid", 1'b0, rdata_valid);
        reset = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_failure($sformatf("cannot open stimulus file %s", STIM_FILE));
        end else begin
            run_stimulus(fd);
            $fclose(fd);
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (lines_known);
        #((line_count + 20) * CLK_PERIOD * 2);
        $display("Timeout: the stimulus did not finish in the allowed time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- source/plus_video.sv
`timescale 1ns/1ps

module plus_video (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              plus_mode,
    input  video_reg_pkg::cpu_bus_t           cpu,
    input  video_pixel_pkg::pixel_in_t        pix,
    output logic [video_reg_pkg::DATA_W-1:0]  rdata,
    output logic                              rdata_valid,
    output video_pixel_pkg::rgb_t             rgb_out
);

    video_reg_pkg::video_ctrl_t     ctrl;
    video_pixel_pkg::pal_index_t    pal_index;
    video_pixel_pkg::rgb_t          pal_color;
    video_pixel_pkg::raster_pos_t   pos;

    ////////////////////////////////////////////////////////////
    // Register block, steers the pipeline
    ////////////////////////////////////////////////////////////

    video_regs u_regs (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .plus_mode   (plus_mode),
        .cpu         (cpu),
        .pal_index   (pal_index),
        .pal_color   (pal_color),
        .ctrl        (ctrl),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    // Raster position for the mode effects
    raster_counter u_raster (
        .clk_sys (clk_sys),
        .reset   (reset),
        .pix     (pix),
        .pos     (pos)
    );

    ////////////////////////////////////////////////////////////
    // Colour pipeline, two cycles input to output
    ////////////////////////////////////////////////////////////

    pixel_pipeline u_pipe (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .pix       (pix),
        .pos       (pos),
        .ctrl      (ctrl),
        .pal_index (pal_index),
        .pal_color (pal_color),
        .rgb_out   (rgb_out)
    );

endmodule

//--- source/pixel_pipeline.sv
`timescale 1ns/1ps

module pixel_pipeline (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  video_pixel_pkg::pixel_in_t    pix,
    input  video_pixel_pkg::raster_pos_t  pos,
    input  video_reg_pkg::video_ctrl_t    ctrl,
    output video_pixel_pkg::pal_index_t   pal_index,
    input  video_pixel_pkg::rgb_t         pal_color,
    output video_pixel_pkg::rgb_t         rgb_out
);

    video_pixel_pkg::pixel_in_t    pix_q;
    video_reg_pkg::video_ctrl_t    ctrl_q;
    video_pixel_pkg::rgb_t         sprite_q;
    video_pixel_pkg::rgb_t         next_rgb;

    // Halve every channel
    function automatic video_pixel_pkg::rgb_t halve(input video_pixel_pkg::rgb_t c);
        video_pixel_pkg::rgb_t h;
        h.r = c.r >> 1;
        h.g = c.g >> 1;
        h.b = c.b >> 1;
        return h;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stage 1
    ////////////////////////////////////////////////////////////

    // Palette is read on the incoming pixel, colour held with it
    assign pal_index = pix.sprite_index;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pix_q       <= '0;
            ctrl_q.mode <= video_reg_pkg::MODE_NORMAL;
            ctrl_q.plus <= 1'b0;
        end else begin
            pix_q  <= pix;
            ctrl_q <= ctrl;
        end
    end

    always_ff @(posedge clk_sys) begin
        sprite_q <= pal_color;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2
    ////////////////////////////////////////////////////////////

    // pos lines up with pix_q, both one cycle after the input
    always_comb begin
        next_rgb = pix_q.colour;
        if (ctrl_q.plus) begin
            if (pix_q.hblank || pix_q.vblank) begin
                next_rgb = video_pixel_pkg::BLACK;
            end else if (pix_q.sprite_active) begin
                next_rgb = sprite_q;
            end else begin
                case (ctrl_q.mode)
                    video_reg_pkg::MODE_DOUBLE_WIDTH: begin
                        // Odd columns repeat the last output
                        if (pos.h[0]) begin
                            next_rgb = rgb_out;
                        end
                    end
                    video_reg_pkg::MODE_SCANLINE: begin
                        if (pos.v[0]) begin
                            next_rgb = halve(pix_q.colour);
                        end
                    end
                    video_reg_pkg::MODE_SHADOW: begin
                        next_rgb = halve(pix_q.colour);
                    end
                    default: begin
                        next_rgb = pix_q.colour;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rgb_out <= video_pixel_pkg::BLACK;
        end else begin
            rgb_out <= next_rgb;
        end
    end

    // Blanked Plus-mode pixel comes out black two edges later
    a_blank_black: assert property (@(posedge clk_sys) disable iff (reset)
        (ctrl.plus && (pix.hblank || pix.vblank))
        |-> ##2 (rgb_out == video_pixel_pkg::BLACK));

endmodule

//--- source/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  video_pixel_pkg::pixel_in_t    pix,
    output video_pixel_pkg::raster_pos_t  pos
);

    logic hblank_q;
    logic hblank_start;

    // First cycle of a horizontal blanking period
    assign hblank_start = pix.hblank && !hblank_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hblank_q <= 1'b0;
        end else begin
            hblank_q <= pix.hblank;
        end
    end

    ////////////////////////////////////////////////////////////
    // Horizontal position
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset || pix.hblank) begin
            pos.h <= '0;
        end else begin
            pos.h <= pos.h + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Vertical position
    ////////////////////////////////////////////////////////////

    // vblank wins over the line step
    always_ff @(posedge clk_sys) begin
        if (reset || pix.vblank) begin
            pos.v <= '0;
        end else if (hblank_start) begin
            pos.v <= pos.v + 1'b1;
        end
    end

endmodule

//--- source/video_regs.sv
`timescale 1ns/1ps

module video_regs (
    input  logic                                 clk_sys,
    input  logic                                 reset,
    input  logic                                 plus_mode,
    input  video_reg_pkg::cpu_bus_t              cpu,
    input  video_pixel_pkg::pal_index_t          pal_index,
    output video_pixel_pkg::rgb_t                pal_color,
    output video_reg_pkg::video_ctrl_t           ctrl,
    output logic [video_reg_pkg::DATA_W-1:0]     rdata,
    output logic                                 rdata_valid
);

    logic [video_reg_pkg::MODE_W-1:0]   mode_q;
    logic                               enable_q;
    video_pixel_pkg::rgb_t              palette [video_pixel_pkg::PAL_ENTRIES];

    logic                               pal_hit;
    logic                               wr_en;
    video_reg_pkg::video_mode_e         eff_mode;
    logic [video_reg_pkg::DATA_W-1:0]   rd_byte;

    assign pal_hit = (cpu.addr[15:4] == video_reg_pkg::PAL_PAGE);
    assign wr_en   = plus_mode && cpu.wr;

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mode_q   <= '0;
            enable_q <= 1'b0;
            for (int i = 0; i < video_pixel_pkg::PAL_ENTRIES; i++) begin
                palette[i] <= video_pixel_pkg::BLACK;
            end
        end else if (wr_en) begin
            if (cpu.addr[7:0] == video_reg_pkg::ADDR_VIDEO_MODE) begin
                mode_q <= cpu.wdata;
            end
            if (cpu.addr[7:0] == video_reg_pkg::ADDR_CONFIG_MODE) begin
                enable_q <= cpu.wdata[0];
            end
            // Entry packed as r, g, b from bit 5 down
            if (pal_hit) begin
                palette[cpu.addr[3:0]] <= video_pixel_pkg::rgb_t'(cpu.wdata[5:0]);
            end
        end
    end

    // Sprite colour lookup for the pipeline
    assign pal_color = palette[pal_index];

    // Unknown mode codes fall back to normal
    always_comb begin
        eff_mode = video_reg_pkg::MODE_NORMAL;
        if (enable_q) begin
            case (mode_q)
                video_reg_pkg::MODE_DOUBLE_WIDTH: eff_mode = video_reg_pkg::MODE_DOUBLE_WIDTH;
                video_reg_pkg::MODE_SCANLINE:     eff_mode = video_reg_pkg::MODE_SCANLINE;
                video_reg_pkg::MODE_SHADOW:       eff_mode = video_reg_pkg::MODE_SHADOW;
                default:                          eff_mode = video_reg_pkg::MODE_NORMAL;
            endcase
        end
    end

    always_comb begin
        ctrl.mode = eff_mode;
        ctrl.plus = plus_mode;
    end

    ////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_byte = '0;
        if (pal_hit) begin
            rd_byte = {{(video_reg_pkg::DATA_W - $bits(video_pixel_pkg::rgb_t)){1'b0}},
                       palette[cpu.addr[3:0]]};
        end else if (cpu.addr[7:0] == video_reg_pkg::ADDR_VIDEO_MODE) begin
            rd_byte = mode_q;
        end else if (cpu.addr[7:0] == video_reg_pkg::ADDR_CONFIG_MODE) begin
            rd_byte = {{(video_reg_pkg::DATA_W - 1){1'b0}}, enable_q};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cpu.rd;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cpu.rd) begin
            rdata <= rd_byte;
        end
    end

    // CPU never issues a read and a write in the same cycle
    a_no_wr_rd: assert property (@(posedge clk_sys) disable iff (reset)
        !(cpu.wr && cpu.rd));

endmodule

//--- source/video_reg_pkg.sv
package video_reg_pkg;

    ////////////////////////////////////////////////////////////
    // Register widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int MODE_W = 8;

    // Mode codes as seen by the CPU
    typedef enum logic [MODE_W-1:0] {
        MODE_NORMAL       = 8'h00,
        MODE_DOUBLE_WIDTH = 8'h01,
        MODE_SCANLINE     = 8'h04,
        MODE_SHADOW       = 8'h05
    } video_mode_e;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    // Decoded on address bits 7:0 only
    localparam logic [7:0] ADDR_VIDEO_MODE  = 8'h82;
    localparam logic [7:0] ADDR_CONFIG_MODE = 8'h90;

    // Palette page, compared against address bits 15:4
    localparam logic [11:0] PAL_PAGE = 12'h7F6;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              wr;
        logic              rd;
    } cpu_bus_t;

    typedef struct packed {
        video_mode_e mode;
        logic        plus;
    } video_ctrl_t;

endpackage

//--- source/video_pixel_pkg.sv
package video_pixel_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int CHAN_W      = 2;
    localparam int INDEX_W     = 4;
    localparam int POS_W       = 9;
    localparam int PAL_ENTRIES = 16;

    ////////////////////////////////////////////////////////////
    // Colour and pixel types
    ////////////////////////////////////////////////////////////

    typedef logic [CHAN_W-1:0] chan_t;

    // Red sits in the top bits, blue in the bottom
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    typedef logic [INDEX_W-1:0] pal_index_t;

    localparam rgb_t BLACK = '0;

    typedef struct packed {
        logic [POS_W-1:0] h;
        logic [POS_W-1:0] v;
    } raster_pos_t;

    // One pixel from the video source, sprite index already resolved
    typedef struct packed {
        logic       hblank;
        logic       vblank;
        rgb_t       colour;
        logic       sprite_active;
        pal_index_t sprite_index;
    } pixel_in_t;

endpackage
